/* common/consolePkg.sv */
package consolePkg;

    // screen geometry, the address map below depends on it
    localparam int textColumns = 80;
    localparam int textRows = 25;
    localparam int cellCount = textColumns * textRows;

    typedef logic [7:0] Char_t;
    typedef logic [7:0] ScanCode_t;
    typedef logic [10:0] CellAddr_t;   // row * 80 + column
    typedef logic [6:0] Column_t;
    typedef logic [4:0] Row_t;

    typedef struct packed {
        Row_t row;
        Column_t column;
    } Cursor_t;

    // one character from an input path, valid for a single cycle
    typedef struct packed {
        logic valid;
        Char_t code;
    } CharEvent_t;

    typedef struct packed {
        logic enable;
        CellAddr_t address;
        Char_t data;
    } CellWrite_t;

    // wishbone word address, cells at 0..1999
    typedef logic [11:0] WbAddr_t;
    localparam WbAddr_t cursorColumnAddr = 12'd2048;
    localparam WbAddr_t cursorRowAddr = 12'd2049;

    typedef struct packed {
        logic cycle;
        logic strobe;
        logic writeEnable;
        WbAddr_t address;
        Char_t writeData;
    } WbRequest_t;

    typedef struct packed {
        logic ack;
        Char_t readData;
    } WbResponse_t;

    // control characters the writer acts on
    localparam Char_t charCarriageReturn = 8'h0D;
    localparam Char_t charLineFeed = 8'h0A;
    localparam Char_t charBackspace = 8'h08;

endpackage

/* uart/uartReceiver.sv */
module uartReceiver #(
    parameter int clocksPerBit = 434
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   rx,
    output consolePkg::CharEvent_t charOut
);

    localparam int countWidth = $clog2(clocksPerBit);

    typedef enum logic [1:0] {
        stateIdle,
        stateStart,
        stateData,
        stateStop
    } State_t;

    State_t state;
    logic [1:0] rxSync;
    logic rxLine;
    logic [countWidth-1:0] bitTimer;
    logic [2:0] bitIndex;
    logic halfDone;
    logic timerDone;
    logic validReg;
    consolePkg::Char_t shiftReg;

    // two flops against metastability, line idles high
    always_ff @(posedge clk) begin
        if (reset) rxSync <= 2'b11;
        else rxSync <= {rxSync[0], rx};
    end

    assign rxLine = rxSync[1];
    assign halfDone = bitTimer == countWidth'(clocksPerBit / 2 - 1);
    assign timerDone = bitTimer == countWidth'(clocksPerBit - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stateIdle;
            bitTimer <= '0;
            bitIndex <= '0;
            validReg <= 1'b0;
        end else begin
            validReg <= 1'b0;
            bitTimer <= bitTimer + 1'b1;
            case (state)
                stateIdle: begin
                    bitTimer <= '0;
                    if (!rxLine) state <= stateStart;   // falling start edge
                end
                stateStart: if (halfDone) begin
                    bitTimer <= '0;
                    bitIndex <= '0;
                    state <= rxLine ? stateIdle : stateData;   // reject glitches
                end
                stateData: if (timerDone) begin
                    bitTimer <= '0;
                    bitIndex <= bitIndex + 1'b1;
                    if (bitIndex == 3'd7) state <= stateStop;
                end
                stateStop: if (timerDone) begin
                    validReg <= rxLine;   // framing error drops the byte
                    state <= stateIdle;
                end
                default: state <= stateIdle;
            endcase
        end
    end

    // lsb first, sampled at bit centers
    always_ff @(posedge clk) begin
        if (state == stateData && timerDone) shiftReg <= {rxLine, shiftReg[7:1]};
    end

    assign charOut = '{valid: validReg, code: shiftReg};

    validOnlyAfterStop: assert property (@(posedge clk) disable iff (reset)
        validReg |-> $past(state) == stateStop);

endmodule

/* ps2/scanCodeMap.sv */
module scanCodeMap (
    input  consolePkg::ScanCode_t scanCode,
    input  logic                  shift,
    output consolePkg::Char_t     charCode
);

    consolePkg::Char_t baseCode;

    // scan code set 2, lower case by default
    always_comb begin
        case (scanCode)
            8'h1C: baseCode = "a";
            8'h32: baseCode = "b";
            8'h21: baseCode = "c";
            8'h23: baseCode = "d";
            8'h24: baseCode = "e";
            8'h2B: baseCode = "f";
            8'h34: baseCode = "g";
            8'h33: baseCode = "h";
            8'h43: baseCode = "i";
            8'h3B: baseCode = "j";
            8'h42: baseCode = "k";
            8'h4B: baseCode = "l";
            8'h3A: baseCode = "m";
            8'h31: baseCode = "n";
            8'h44: baseCode = "o";
            8'h4D: baseCode = "p";
            8'h15: baseCode = "q";
            8'h2D: baseCode = "r";
            8'h1B: baseCode = "s";
            8'h2C: baseCode = "t";
            8'h3C: baseCode = "u";
            8'h2A: baseCode = "v";
            8'h1D: baseCode = "w";
            8'h22: baseCode = "x";
            8'h35: baseCode = "y";
            8'h1A: baseCode = "z";
            8'h45: baseCode = "0";
            8'h16: baseCode = "1";
            8'h1E: baseCode = "2";
            8'h26: baseCode = "3";
            8'h25: baseCode = "4";
            8'h2E: baseCode = "5";
            8'h36: baseCode = "6";
            8'h3D: baseCode = "7";
            8'h3E: baseCode = "8";
            8'h46: baseCode = "9";
            8'h29: baseCode = " ";
            8'h5A: baseCode = consolePkg::charCarriageReturn;   // enter
            8'h66: baseCode = consolePkg::charBackspace;
            default: baseCode = '0;
        endcase
    end

    // shift only affects letters
    always_comb begin
        if (shift && baseCode >= "a" && baseCode <= "z") charCode = baseCode - 8'h20;
        else charCode = baseCode;
    end

endmodule

/* ps2/ps2Receiver.sv */
module ps2Receiver (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ps2Clk,
    input  logic                   ps2Data,
    output consolePkg::CharEvent_t charOut
);

    localparam consolePkg::ScanCode_t breakPrefix = 8'hF0;
    localparam consolePkg::ScanCode_t leftShiftCode = 8'h12;
    localparam consolePkg::ScanCode_t rightShiftCode = 8'h59;

    logic [1:0] clkSync;
    logic [1:0] dataSync;
    logic clkPrev;
    logic fallEdge;
    logic [10:0] frame;   // start, 8 data, parity, stop
    logic [3:0] bitCount;
    logic frameReady;
    logic frameGood;
    logic breakPending;
    logic leftShift;
    logic rightShift;
    logic validReg;
    consolePkg::Char_t codeReg;
    consolePkg::ScanCode_t scanCode;
    consolePkg::Char_t mappedChar;

    always_ff @(posedge clk) begin
        if (reset) begin
            clkSync <= 2'b11;
            dataSync <= 2'b11;
            clkPrev <= 1'b1;
        end else begin
            clkSync <= {clkSync[0], ps2Clk};
            dataSync <= {dataSync[0], ps2Data};
            clkPrev <= clkSync[1];
        end
    end

    assign fallEdge = clkPrev && !clkSync[1];

    always_ff @(posedge clk) begin
        if (fallEdge) frame <= {dataSync[1], frame[10:1]};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bitCount <= '0;
            frameReady <= 1'b0;
        end else begin
            frameReady <= fallEdge && bitCount == 4'd10;
            if (fallEdge) bitCount <= (bitCount == 4'd10) ? 4'd0 : bitCount + 1'b1;
        end
    end

    assign scanCode = frame[8:1];
    assign frameGood = !frame[0] && frame[10] && (^frame[9:1]);   // odd parity

    scanCodeMap keyMap (
        .scanCode,
        .shift(leftShift || rightShift),
        .charCode(mappedChar)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            breakPending <= 1'b0;
            leftShift <= 1'b0;
            rightShift <= 1'b0;
            validReg <= 1'b0;
        end else begin
            validReg <= 1'b0;
            if (frameReady && frameGood) begin
                if (scanCode == breakPrefix) begin
                    breakPending <= 1'b1;
                end else if (breakPending) begin   // key release
                    breakPending <= 1'b0;
                    if (scanCode == leftShiftCode) leftShift <= 1'b0;
                    if (scanCode == rightShiftCode) rightShift <= 1'b0;
                end else if (scanCode == leftShiftCode) begin
                    leftShift <= 1'b1;
                end else if (scanCode == rightShiftCode) begin
                    rightShift <= 1'b1;
                end else begin
                    validReg <= mappedChar != '0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (frameReady) codeReg <= mappedChar;
    end

    assign charOut = '{valid: validReg, code: codeReg};

    bitCountInRange: assert property (@(posedge clk) disable iff (reset) bitCount <= 4'd10);

endmodule

/* hw/consoleWriter.sv */
module consoleWriter (
    input  logic                   clk,
    input  logic                   reset,
    input  consolePkg::CharEvent_t uartChar,
    input  consolePkg::CharEvent_t keyChar,
    output consolePkg::CellWrite_t cellWrite,
    output consolePkg::Cursor_t    cursor
);

    localparam consolePkg::Column_t lastColumn =
        consolePkg::Column_t'(consolePkg::textColumns - 1);
    localparam consolePkg::Row_t lastRow = consolePkg::Row_t'(consolePkg::textRows - 1);

    consolePkg::CharEvent_t uartSlot;
    consolePkg::CharEvent_t keySlot;
    logic takeUart;
    logic takeKey;
    logic active;
    logic printable;
    consolePkg::Char_t current;
    consolePkg::Row_t rowAdvanced;
    consolePkg::Cursor_t nextCursor;
    consolePkg::CellAddr_t cellAddr;
    logic writeEnable;
    consolePkg::CellAddr_t writeAddr;
    consolePkg::Char_t writeData;

    // one pending slot per source, uart has priority
    assign takeUart = uartSlot.valid;
    assign takeKey = keySlot.valid && !uartSlot.valid;
    assign active = takeUart || takeKey;
    assign current = takeUart ? uartSlot.code : keySlot.code;

    always_ff @(posedge clk) begin
        if (reset) begin
            uartSlot <= '0;
            keySlot <= '0;
        end else begin
            if (uartChar.valid) uartSlot <= uartChar;   // overwrites a full slot
            else if (takeUart) uartSlot.valid <= 1'b0;
            if (keyChar.valid) keySlot <= keyChar;
            else if (takeKey) keySlot.valid <= 1'b0;
        end
    end

    assign printable = current >= 8'h20 && current <= 8'h7E;
    assign rowAdvanced = (cursor.row == lastRow) ? '0 : cursor.row + 1'b1;   // no scrolling
    assign cellAddr = consolePkg::CellAddr_t'(cursor.row) * consolePkg::CellAddr_t'(80)
        + consolePkg::CellAddr_t'(cursor.column);

    always_comb begin
        nextCursor = cursor;
        if (active) begin
            if (printable) begin
                if (cursor.column == lastColumn) begin
                    nextCursor.column = '0;
                    nextCursor.row = rowAdvanced;
                end else begin
                    nextCursor.column = cursor.column + 1'b1;
                end
            end else if (current == consolePkg::charCarriageReturn) begin
                nextCursor.column = '0;
            end else if (current == consolePkg::charLineFeed) begin
                nextCursor.row = rowAdvanced;
            end else if (current == consolePkg::charBackspace && cursor.column != '0) begin
                nextCursor.column = cursor.column - 1'b1;
            end
            // anything else is dropped
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cursor <= '0;
            writeEnable <= 1'b0;
        end else begin
            cursor <= nextCursor;
            writeEnable <= active && printable;
        end
    end

    // cell write lands at the old cursor position
    always_ff @(posedge clk) begin
        writeAddr <= cellAddr;
        writeData <= current;
    end

    assign cellWrite = '{enable: writeEnable, address: writeAddr, data: writeData};

    columnInRange: assert property (@(posedge clk) disable iff (reset)
        cursor.column < consolePkg::textColumns);
    rowInRange: assert property (@(posedge clk) disable iff (reset)
        cursor.row < consolePkg::textRows);

endmodule

/* hw/textBuffer.sv */
module textBuffer (
    input  logic                    clk,
    input  logic                    reset,
    input  consolePkg::CellWrite_t  cellWrite,
    input  consolePkg::Cursor_t     cursor,
    input  consolePkg::WbRequest_t  wbRequest,
    output consolePkg::WbResponse_t wbResponse
);

    consolePkg::Char_t cells [consolePkg::cellCount];
    logic request;
    logic isCell;
    logic ackReg;
    consolePkg::Char_t readReg;
    consolePkg::CellAddr_t hostCell;

    // new request only while ack is low, no wait states
    assign request = wbRequest.cycle && wbRequest.strobe && !ackReg;
    assign isCell = wbRequest.address < consolePkg::WbAddr_t'(consolePkg::cellCount);
    assign hostCell = wbRequest.address[10:0];

    always_ff @(posedge clk) begin
        if (request && wbRequest.writeEnable && isCell) cells[hostCell] <= wbRequest.writeData;
        // writer port last, so it wins on the same cell
        if (cellWrite.enable) cells[cellWrite.address] <= cellWrite.data;
    end

    always_ff @(posedge clk) begin
        if (request) begin
            if (isCell) readReg <= cells[hostCell];
            else if (wbRequest.address == consolePkg::cursorColumnAddr)
                readReg <= {1'b0, cursor.column};
            else if (wbRequest.address == consolePkg::cursorRowAddr)
                readReg <= {3'b000, cursor.row};
            else readReg <= '0;   // unused addresses
        end
    end

    always_ff @(posedge clk) begin
        if (reset) ackReg <= 1'b0;
        else ackReg <= request;   // single cycle ack
    end

    assign wbResponse = '{ack: ackReg, readData: readReg};

    ackFollowsStrobe: assert property (@(posedge clk) disable iff (reset)
        ackReg |-> $past(wbRequest.cycle && wbRequest.strobe));

endmodule

/* hw/consoleTop.sv */
module consoleTop #(
    parameter int clocksPerBit = 434
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    uartRx,
    input  logic                    ps2Clk,
    input  logic                    ps2Data,
    input  consolePkg::WbRequest_t  wbRequest,
    output consolePkg::WbResponse_t wbResponse
);

    consolePkg::CharEvent_t uartChar;
    consolePkg::CharEvent_t keyChar;
    consolePkg::CellWrite_t cellWrite;
    consolePkg::Cursor_t cursor;

    // serial input path
    uartReceiver #(
        .clocksPerBit(clocksPerBit)
    ) serialInput (
        .clk,
        .reset,
        .rx(uartRx),
        .charOut(uartChar)
    );

    // keyboard input path
    ps2Receiver keyboardInput (
        .clk,
        .reset,
        .ps2Clk,
        .ps2Data,
        .charOut(keyChar)
    );

    consoleWriter writer (
        .clk,
        .reset,
        .uartChar,
        .keyChar,
        .cellWrite,
        .cursor
    );

    textBuffer buffer (
        .clk,
        .reset,
        .cellWrite,
        .cursor,
        .wbRequest,
        .wbResponse
    );

endmodule

/* sim/consoleTb.sv */
module consoleTb;

    localparam int clocksPerBit = 8;
    localparam int cycleLimit = 400000;   // about ten times the expected run
    localparam int keyCount = 10;

    logic clk;
    logic reset;
    logic uartRx;
    logic ps2Clk;
    logic ps2Data;
    consolePkg::WbRequest_t wbRequest;
    consolePkg::WbResponse_t wbResponse;

    int errorCount = 0;
    int cycleCount = 0;
    consolePkg::Char_t modelCells [consolePkg::cellCount];
    consolePkg::Cursor_t modelCursor;

    // set 2 make codes with the six letters first
    consolePkg::ScanCode_t keyCodes [keyCount] =
        '{8'h1C, 8'h32, 8'h21, 8'h1A, 8'h15, 8'h44, 8'h16, 8'h45, 8'h46, 8'h29};
    consolePkg::Char_t keyChars [keyCount] =
        '{"a", "b", "c", "z", "q", "o", "1", "0", "9", " "};
    consolePkg::Char_t keyShifted [keyCount] =   // same keys with shift held
        '{"A", "B", "C", "Z", "Q", "O", "1", "0", "9", " "};

    consoleTop #(
        .clocksPerBit(clocksPerBit)
    ) UUT (
        .clk,
        .reset,
        .uartRx,
        .ps2Clk,
        .ps2Data,
        .wbRequest,
        .wbResponse
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == cycleLimit) begin
            $display("Timeout: no result after %0d cycles", cycleLimit);
            $display("Errors: %0d", errorCount);
            $display("Simulation failed");
            $finish;
        end
    end

    // called and returns 1 unit after a rising edge
    task automatic waitCycles(input int count);
        repeat (count) @(posedge clk);
        #1;
    endtask

    task automatic sendSerial(input consolePkg::Char_t value);
        uartRx = 1'b0;   // start bit
        waitCycles(clocksPerBit);
        for (int i = 0; i < 8; i++) begin
            uartRx = value[i];
            waitCycles(clocksPerBit);
        end
        uartRx = 1'b1;
        waitCycles(clocksPerBit);
    endtask

    task automatic sendKeyByte(input consolePkg::ScanCode_t code);
        logic [10:0] frame;
        frame = {1'b1, ~^code, code, 1'b0};   // stop, odd parity, data, start
        for (int i = 0; i < 11; i++) begin
            ps2Data = frame[i];
            waitCycles(4);
            ps2Clk = 1'b0;
            waitCycles(4);
            ps2Clk = 1'b1;
        end
    endtask

    task automatic wbAccess(input logic write, input consolePkg::WbAddr_t addr,
                            input consolePkg::Char_t writeData,
                            output consolePkg::Char_t readData);
        wbRequest = '{cycle: 1'b1, strobe: 1'b1, writeEnable: write, address: addr,
                      writeData: writeData};
        waitCycles(1);
        while (!wbResponse.ack) waitCycles(1);
        readData = wbResponse.readData;
        wbRequest = '0;
    endtask

    task automatic wbWrite(input consolePkg::WbAddr_t addr, input consolePkg::Char_t data);
        consolePkg::Char_t unused;
        wbAccess(1'b1, addr, data, unused);
    endtask

    task automatic wbRead(input consolePkg::WbAddr_t addr, output consolePkg::Char_t data);
        wbAccess(1'b0, addr, '0, data);
    endtask

    task automatic readCursor(output consolePkg::Cursor_t value);
        consolePkg::Char_t column;
        consolePkg::Char_t row;
        wbRead(consolePkg::cursorColumnAddr, column);
        wbRead(consolePkg::cursorRowAddr, row);
        value = '{row: row[4:0], column: column[6:0]};
    endtask

    function automatic int cellIndex(input consolePkg::Cursor_t position);
        return int'(position.row) * consolePkg::textColumns + int'(position.column);
    endfunction

    // reference console rules
    task automatic applyModel(input consolePkg::Char_t code);
        consolePkg::Row_t nextRow;
        if (int'(modelCursor.row) == consolePkg::textRows - 1) nextRow = '0;
        else nextRow = modelCursor.row + 5'd1;
        if (code >= 8'h20 && code <= 8'h7E) begin
            modelCells[cellIndex(modelCursor)] = code;
            if (int'(modelCursor.column) == consolePkg::textColumns - 1) begin
                modelCursor.column = '0;
                modelCursor.row = nextRow;
            end else begin
                modelCursor.column = modelCursor.column + 7'd1;
            end
        end else if (code == consolePkg::charCarriageReturn) begin
            modelCursor.column = '0;
        end else if (code == consolePkg::charLineFeed) begin
            modelCursor.row = nextRow;
        end else if (code == consolePkg::charBackspace && modelCursor.column != '0) begin
            modelCursor.column = modelCursor.column - 7'd1;
        end
    endtask

    task automatic checkChar(input string testName, input consolePkg::Char_t expected,
                             input consolePkg::Char_t actual);
        if (actual !== expected) begin
            errorCount++;
            $display("FAIL %s: expected %h, actual %h", testName, expected, actual);
        end
    endtask

    task automatic checkCursor(input string testName, input consolePkg::Cursor_t expected,
                               input consolePkg::Cursor_t actual);
        if (actual !== expected) begin
            errorCount++;
            $display("FAIL %s: expected row %0d column %0d, actual row %0d column %0d",
                testName, expected.row, expected.column, actual.row, actual.column);
        end
    endtask

    task automatic checkStep(input string testName, input int addr);
        consolePkg::Char_t data;
        consolePkg::Cursor_t position;
        wbRead(consolePkg::WbAddr_t'(addr), data);
        checkChar(testName, modelCells[addr], data);
        readCursor(position);
        checkCursor(testName, modelCursor, position);
    endtask

    task automatic typeSerial(input string testName, input consolePkg::Char_t code);
        int addr;
        sendSerial(code);
        waitCycles(10);
        addr = cellIndex(modelCursor);
        applyModel(code);
        checkStep(testName, addr);
    endtask

    // expected is 0 for codes the keyboard path drops
    task automatic typeKey(input string testName, input consolePkg::ScanCode_t code,
                           input consolePkg::Char_t expected);
        int addr;
        sendKeyByte(code);
        waitCycles(10);
        addr = cellIndex(modelCursor);
        applyModel(expected);
        checkStep(testName, addr);
    endtask

    initial begin
        int idx;
        int addrFirst;
        int addrSecond;
        int keyIndex;
        logic shiftOn;
        consolePkg::ScanCode_t shiftCode;
        consolePkg::Char_t data;
        consolePkg::Char_t code;
        consolePkg::Char_t expected;
        consolePkg::Cursor_t position;

        void'($urandom(32'h8ec0));
        reset = 1'b1;
        uartRx = 1'b1;
        ps2Clk = 1'b1;
        ps2Data = 1'b1;
        wbRequest = '0;
        modelCursor = '0;
        waitCycles(3);
        reset = 1'b0;
        waitCycles(2);

        readCursor(position);
        checkCursor("reset cursor", '0, position);
        for (idx = 0; idx < consolePkg::cellCount; idx++) begin
            wbWrite(consolePkg::WbAddr_t'(idx), " ");
            modelCells[idx] = " ";
        end
        repeat (60) begin
            idx = $urandom_range(consolePkg::cellCount - 1);
            wbRead(consolePkg::WbAddr_t'(idx), data);
            checkChar("clear readback", modelCells[idx], data);
        end

        repeat (40) typeSerial("uart text", 8'($urandom_range(8'h7E, 8'h20)));

        repeat (24) begin
            keyIndex = $urandom_range(keyCount - 1);
            shiftOn = 1'($urandom_range(1));
            shiftCode = $urandom_range(1) ? 8'h12 : 8'h59;   // left or right shift
            if (shiftOn) typeKey("shift press", shiftCode, '0);
            expected = shiftOn ? keyShifted[keyIndex] : keyChars[keyIndex];
            typeKey("keyboard text", keyCodes[keyIndex], expected);
            sendKeyByte(8'hF0);
            typeKey("key release", keyCodes[keyIndex], '0);
            if (shiftOn) begin
                sendKeyByte(8'hF0);
                typeKey("shift release", shiftCode, '0);
            end
        end

        repeat (40) begin
            case ($urandom_range(7))
                0: typeSerial("control", consolePkg::charCarriageReturn);
                1: typeSerial("control", consolePkg::charLineFeed);
                2: typeSerial("control", consolePkg::charBackspace);
                3: typeSerial("ignored code", $urandom_range(1) ? 8'h1B : 8'hC3);
                4: typeSerial("ignored code", $urandom_range(1) ? 8'h7F : 8'h00);
                5: typeKey("key enter", 8'h5A, consolePkg::charCarriageReturn);
                6: typeKey("key backspace", 8'h66, consolePkg::charBackspace);
                default: typeKey("key unmapped", 8'h05, '0);
            endcase
        end
        typeSerial("control", consolePkg::charCarriageReturn);
        typeSerial("backspace at column 0", consolePkg::charBackspace);

        // go to the last row and wrap past the last cell
        typeSerial("wrap", consolePkg::charCarriageReturn);
        while (int'(modelCursor.row) != consolePkg::textRows - 1)
            typeSerial("wrap", consolePkg::charLineFeed);
        repeat (consolePkg::textColumns + 6)
            typeSerial("wrap", 8'($urandom_range(8'h7E, 8'h20)));

        repeat (3) begin
            keyIndex = $urandom_range(5);
            code = 8'($urandom_range(8'h39, 8'h30));   // digits differ from the letter keys
            fork
                begin
                    waitCycles(9);   // serial byte then ends with the key frame
                    sendSerial(code);
                end
                sendKeyByte(keyCodes[keyIndex]);
            join
            waitCycles(10);
            addrFirst = cellIndex(modelCursor);
            applyModel(code);
            addrSecond = cellIndex(modelCursor);
            applyModel(keyChars[keyIndex]);
            wbRead(consolePkg::WbAddr_t'(addrFirst), data);
            checkChar("same cycle uart", modelCells[addrFirst], data);
            wbRead(consolePkg::WbAddr_t'(addrSecond), data);
            checkChar("same cycle key", modelCells[addrSecond], data);
            readCursor(position);
            checkCursor("same cycle cursor", modelCursor, position);
        end

        $display("Errors: %0d", errorCount);
        if (errorCount == 0) $display("Simulation passed");
        else $display("Simulation failed");
        $finish;
    end

endmodule

/* tb.f */
common/consolePkg.sv
uart/uartReceiver.sv
ps2/scanCodeMap.sv
ps2/ps2Receiver.sv
hw/consoleWriter.sv
hw/textBuffer.sv
hw/consoleTop.sv
sim/consoleTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the console testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module consoleTb -o consoleSim
./obj_dir/consoleSim | tee sim.log

if grep -qx "Simulation passed" sim.log; then
    echo "run.sh: pass"
else
    echo "run.sh: fail"
    exit 1
fi
